// ==== project.f ====
+incdir+sim
verilog/log_arith_pkg.sv
verilog/stage1_log2_approx.sv
verilog/stage2_log_combine.sv
verilog/stage3_antilog.sv
verilog/job_ctrl.sv
verilog/job_counter.sv
verilog/log_arith_top.sv
sim/log_arith_tb.sv

// ==== sim/log_arith_model.svh ====
`ifndef LOG_ARITH_MODEL_SVH
`define LOG_ARITH_MODEL_SVH

// reference log2 found from the position of the top set bit
function automatic fix_t approx_log2(fix_t x);
    int msb;
    int ip;
    int frac;
    msb = -1;
    for (int i = 0; i < data_w; i++) begin
        if (x[i]) begin
            msb = i;
        end
    end
    if (msb < 0) begin
        return '0;
    end
    ip = msb - frac_w;
    if (msb >= frac_w) begin
        frac = int'(x) >> (msb - frac_w);
    end else begin
        frac = int'(x) << (frac_w - msb);
    end
    frac = frac & ((1 << frac_w) - 1);
    return {ip[int_w-1:0], frac[frac_w-1:0]};
endfunction

// antilog with truncated low bits and saturation above the Q6.10 range
function automatic fix_t antilog_trunc(log_t l);
    int     ip;
    longint mant;
    ip   = int'(l) >>> frac_w;  // floor of the log
    mant = (1 << frac_w) + (int'(l) & ((1 << frac_w) - 1));
    if (ip >= int_w) begin
        return '1;
    end
    if (ip >= 0) begin
        return fix_t'(mant << ip);
    end
    return fix_t'(mant >> (-ip));
endfunction

function automatic fix_t expected_result(arith_op_e op, fix_t a, fix_t b);
    log_t la;
    log_t lb;
    la = $signed(approx_log2(a));
    lb = $signed(approx_log2(b));
    if (a == '0) begin
        return '0;  // a zero dividend or factor wins over a zero divisor
    end
    if (b == '0) begin
        if (op == op_div) begin
            return '1;
        end
        return '0;
    end
    if (op == op_div) begin
        return antilog_trunc(la - lb);
    end
    return antilog_trunc(la + lb);
endfunction

`endif

// ==== sim/log_arith_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module log_arith_tb
    import log_arith_pkg::*;
();

    localparam int n_jobs = 24;

    logic      clk = 1'b0;
    logic      rst;
    logic      hold;
    logic      start;
    arith_op_e start_op;
    job_len_t  start_len;
    logic      in_valid;
    fix_t      in_0;
    fix_t      in_1;
    logic      busy;
    logic      done;
    logic      out_valid;
    fix_t      result;

    arith_op_e job_op [n_jobs];
    job_len_t  job_len [n_jobs];
    int        drain_hold [n_jobs];
    fix_t      item_a [$];
    fix_t      item_b [$];
    int        item_gap [$];
    int        item_hold [$];
    fix_t      exp_q [$];

    arith_op_e cur_op;
    int        cur_len;
    int        sent_cnt;
    int        job_results;
    int        done_cnt;
    int        job_idx;
    int        item_idx;
    int        err_before;
    int        checks;
    int        errors;
    int        cycles;
    int        limit;
    int        total_len;
    int        total_hold;
    int        seed_val;
    logic      running;

    `include "log_arith_model.svh"

    log_arith_top log_arith_top_i (
        .clk      (clk),
        .rst      (rst),
        .hold     (hold),
        .start    (start),
        .start_op (start_op),
        .start_len(start_len),
        .in_valid (in_valid),
        .in_0     (in_0),
        .in_1     (in_1),
        .busy     (busy),
        .done     (done),
        .out_valid(out_valid),
        .result   (result)
    );

    always #5 clk = ~clk;

    function automatic fix_t rand_operand();
        int pick;
        pick = int'($urandom % 8);
        case (pick)
            0: return '0;
            1: return fix_t'($urandom) | 16'hc000;  // large values near saturation
            2: return fix_t'($urandom % 1024);  // below 1.0
            default: return fix_t'($urandom);
        endcase
    endfunction

    task automatic check_result(input fix_t got, input fix_t want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h got %h", $time, what, want, got);
        end
    endtask

    task automatic check_done(input logic got, input logic want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %b got %b", $time, what, want, got);
        end
    endtask

    task automatic gen_jobs();
        int n;
        total_len  = 0;
        total_hold = 0;
        for (int j = 0; j < n_jobs; j++) begin
            n             = (j == 2) ? 0 : int'($urandom % 21);  // job 2 is always empty
            job_op[j]     = arith_op_e'($urandom % 2);
            job_len[j]    = job_len_t'(n);
            drain_hold[j] = ($urandom % 2 == 0) ? int'($urandom % 5) : 0;
            total_len    += n;
            total_hold   += drain_hold[j];
            for (int k = 0; k < n; k++) begin
                item_a.push_back(rand_operand());
                item_b.push_back(rand_operand());
                item_gap.push_back(int'($urandom % 3));
                item_hold.push_back(($urandom % 4 == 0) ? int'($urandom % 4) + 1 : 0);
                total_hold += item_hold[$];
            end
        end
        limit = total_len * 4 + n_jobs * (pipe_depth + 10) + total_hold;
    endtask

    task automatic run_job(input int j);
        int n;
        n = int'(job_len[j]);
        @(negedge clk);
        start       = 1'b1;
        start_op    = job_op[j];
        start_len   = job_len[j];
        cur_op      = job_op[j];
        cur_len     = n;
        sent_cnt    = 0;
        job_results = 0;
        done_cnt    = 0;
        job_idx     = j;
        err_before  = errors;
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            start    = 1'b0;
            in_valid = 1'b0;
            repeat (item_gap[item_idx]) @(negedge clk);
            in_valid = 1'b1;
            in_0     = item_a[item_idx];
            in_1     = item_b[item_idx];
            if (item_hold[item_idx] > 0) begin
                hold = 1'b1;  // the pair waits at the input while the pipeline is frozen
                repeat (item_hold[item_idx]) @(negedge clk);
                hold = 1'b0;
            end
            item_idx++;
        end
        @(negedge clk);
        start     = 1'b1;  // a second start while busy is not taken
        start_op  = arith_op_e'($urandom % 2);
        start_len = job_len_t'($urandom % 20 + 1);
        in_valid  = 1'b1;  // pairs beyond the job length
        in_0      = rand_operand();
        in_1      = rand_operand();
        @(negedge clk);
        start = 1'b0;
        repeat (2) @(negedge clk);
        in_valid = 1'b0;
        if (drain_hold[j] > 0) begin
            hold = 1'b1;
            repeat (drain_hold[j]) @(negedge clk);
            hold = 1'b0;
        end
        while (done_cnt == 0) @(negedge clk);
        repeat (2) @(negedge clk);
        check_done(logic'(done_cnt == 1), 1'b1, "single done pulse per job");
        check_done(busy, 1'b0, "busy after done");
        $display("job %0d %s len %0d results %0d errors %0d",
                 j, cur_op.name(), n, job_results, errors - err_before);
    endtask

    // scoreboard fed on accepted pairs and drained on emitted results
    always @(posedge clk) begin
        fix_t expected;
        if (!rst) begin
            if (out_valid && !hold) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("error at %0t: a result came out with no input pending", $time);
                end else begin
                    expected = exp_q.pop_front();
                    check_result(result, expected,
                                 $sformatf("job %0d item %0d", job_idx, job_results));
                end
                job_results++;
            end
            if (in_valid && busy && !hold && sent_cnt < cur_len) begin
                exp_q.push_back(expected_result(cur_op, in_0, in_1));
                sent_cnt++;
            end
            if (done) begin
                done_cnt++;
                check_done(logic'(exp_q.size() == 0 && job_results == cur_len), 1'b1,
                           "done after the last result");
            end
        end
    end

    always @(posedge clk) begin
        if (running) begin
            cycles++;
            if (cycles > limit) begin
                $display("timeout: the jobs did not finish within %0d cycles", limit);
                $display("Verification failed");
                $finish;
            end
        end
    end

    initial begin
        seed_val    = $urandom(32'h2cc6);
        rst         = 1'b1;
        hold        = 1'b0;
        start       = 1'b0;
        start_op    = op_mul;
        start_len   = '0;
        in_valid    = 1'b0;
        in_0        = '0;
        in_1        = '0;
        cur_op      = op_mul;
        cur_len     = 0;
        sent_cnt    = 0;
        job_results = 0;
        done_cnt    = 0;
        job_idx     = 0;
        item_idx    = 0;
        err_before  = 0;
        checks      = 0;
        errors      = 0;
        cycles      = 0;
        running     = 1'b0;
        gen_jobs();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_done(out_valid, 1'b0, "out_valid before the first start");
            check_done(busy, 1'b0, "busy before the first start");
            check_done(done, 1'b0, "done before the first start");
        end
        running = 1'b1;
        for (int j = 0; j < n_jobs; j++) begin
            run_job(j);
        end
        running = 1'b0;
        $display("jobs %0d checks %0d errors %0d", n_jobs, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/log_arith_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module log_arith_top
    import log_arith_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      hold,
    input  logic      start,
    input  arith_op_e start_op,
    input  job_len_t  start_len,
    input  logic      in_valid,
    input  fix_t      in_0,
    input  fix_t      in_1,
    output logic      busy,
    output logic      done,
    output logic      out_valid,
    output fix_t      result
);

    logic      en;
    arith_op_e op;
    logic      clear;
    logic      valid_in;
    logic      accept_inc;
    logic      emit_inc;
    logic      all_accepted;
    logic      all_emitted;
    logic      s1_valid;
    fix_t      s1_log_0;
    fix_t      s1_in_0;
    fix_t      s1_in_1;
    combine_s  comb;

    assign en       = ~hold;
    assign emit_inc = out_valid & en;  // a held result is counted once

    job_ctrl job_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .start       (start),
        .start_op    (start_op),
        .in_valid    (in_valid),
        .all_accepted(all_accepted),
        .all_emitted (all_emitted),
        .op          (op),
        .clear       (clear),
        .valid_in    (valid_in),
        .accept_inc  (accept_inc),
        .busy        (busy),
        .done        (done)
    );

    job_counter job_counter_i (
        .clk         (clk),
        .rst         (rst),
        .clear       (clear),
        .len         (start_len),
        .accept_inc  (accept_inc),
        .emit_inc    (emit_inc),
        .all_accepted(all_accepted),
        .all_emitted (all_emitted)
    );

    stage1_log2_approx stage1_i (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .valid_in   (valid_in),
        .in_0       (in_0),
        .in_1       (in_1),
        .valid_out  (s1_valid),
        .log_in_0   (s1_log_0),
        .in_0_bypass(s1_in_0),
        .in_1_bypass(s1_in_1)
    );

    stage2_log_combine stage2_i (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .op         (op),
        .valid_in   (s1_valid),
        .log_in_0   (s1_log_0),
        .in_0_bypass(s1_in_0),
        .in_1_bypass(s1_in_1),
        .comb       (comb)
    );

    stage3_antilog stage3_i (
        .clk      (clk),
        .rst      (rst),
        .en       (en),
        .comb     (comb),
        .out_valid(out_valid),
        .result   (result)
    );

endmodule

`default_nettype wire

// ==== verilog/job_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module job_counter
    import log_arith_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     clear,
    input  job_len_t len,
    input  logic     accept_inc,
    input  logic     emit_inc,
    output logic     all_accepted,
    output logic     all_emitted
);

    job_len_t len_r;
    job_len_t accept_cnt;
    job_len_t emit_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            len_r      <= '0;
            accept_cnt <= '0;
            emit_cnt   <= '0;
        end else if (clear) begin
            len_r      <= len;
            accept_cnt <= '0;
            emit_cnt   <= '0;
        end else begin
            if (accept_inc) begin
                accept_cnt <= accept_cnt + 1'b1;
            end
            if (emit_inc) begin
                emit_cnt <= emit_cnt + 1'b1;
            end
        end
    end

    assign all_accepted = (accept_cnt == len_r);
    assign all_emitted  = (emit_cnt == len_r);

endmodule

`default_nettype wire

// ==== verilog/job_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module job_ctrl
    import log_arith_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      hold,
    input  logic      start,
    input  arith_op_e start_op,
    input  logic      in_valid,
    input  logic      all_accepted,
    input  logic      all_emitted,
    output arith_op_e op,
    output logic      clear,
    output logic      valid_in,
    output logic      accept_inc,
    output logic      busy,
    output logic      done
);

    job_state_e state;

    assign clear      = start && (state == st_idle);  // counter latches the length on this edge
    assign valid_in   = in_valid && (state == st_run) && !hold && !all_accepted;
    assign accept_inc = valid_in;
    assign busy       = (state != st_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            op    <= op_mul;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        op    <= start_op;
                        state <= st_run;
                    end
                end
                st_run: begin
                    if (all_accepted) begin
                        if (all_emitted) begin  // only a zero-length job gets here
                            state <= st_idle;
                            done  <= 1'b1;
                        end else begin
                            state <= st_drain;
                        end
                    end
                end
                st_drain: begin
                    if (all_emitted) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/stage3_antilog.sv ====
`timescale 1ns/1ns
`default_nettype none

module stage3_antilog
    import log_arith_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     en,
    input  combine_s comb,
    output logic     out_valid,
    output fix_t     result
);

    logic signed [int_w:0] int_part;
    logic [int_w:0]        shift_mag;
    fix_t                  mant;
    fix_t                  shifted;
    fix_t                  result_next;

    always_comb begin
        int_part  = comb.log_res[data_w:frac_w];
        mant      = fix_t'({1'b1, comb.log_res[frac_w-1:0]});  // implicit leading one
        shift_mag = int_part[int_w] ? -int_part : int_part;

        if (int_part[int_w]) begin
            shifted = mant >> shift_mag;  // results below 1.0 lose their low bits
        end else begin
            shifted = mant << shift_mag;
        end

        if (comb.zero) begin
            result_next = '0;
        end else if (comb.div_zero || int_part >= int_w) begin
            result_next = '1;  // out of Q6.10 range
        end else begin
            result_next = shifted;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (en) begin
            out_valid <= comb.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            result <= result_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/stage2_log_combine.sv ====
`timescale 1ns/1ns
`default_nettype none

module stage2_log_combine
    import log_arith_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      en,
    input  arith_op_e op,
    input  logic      valid_in,
    input  fix_t      log_in_0,
    input  fix_t      in_0_bypass,
    input  fix_t      in_1_bypass,
    output combine_s  comb
);

    logic      v1;
    arith_op_e op_r;
    logic      zero_next;
    logic      div_zero_next;
    logic      zero_r;
    logic      div_zero_r;
    fix_t      log0_r;
    fix_t      b_r;
    lzc_t      lzc_r;
    fix_t      log1;
    log_t      log0_ext;
    log_t      log1_ext;
    combine_s  comb_next;

    always_comb begin
        zero_next     = (in_0_bypass == '0) || (op == op_mul && in_1_bypass == '0);
        div_zero_next = (op == op_div) && (in_1_bypass == '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
        end else if (en) begin
            v1 <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            op_r       <= op;
            zero_r     <= zero_next;
            div_zero_r <= div_zero_next;
            log0_r     <= log_in_0;
            b_r        <= in_1_bypass;
            lzc_r      <= lead_zeros(in_1_bypass);
        end
    end

    always_comb begin
        log1     = log_of(b_r, lzc_r);
        log0_ext = {log0_r[data_w-1], log0_r};  // sign extension of the Q6.10 logs
        log1_ext = {log1[data_w-1], log1};

        comb_next.valid    = v1;
        comb_next.zero     = zero_r;
        comb_next.div_zero = div_zero_r;
        if (op_r == op_div) begin
            comb_next.log_res = log0_ext - log1_ext;
        end else begin
            comb_next.log_res = log0_ext + log1_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            comb.valid <= 1'b0;
        end else if (en) begin
            comb <= comb_next;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/stage1_log2_approx.sv ====
`timescale 1ns/1ns
`default_nettype none

module stage1_log2_approx
    import log_arith_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic valid_in,
    input  fix_t in_0,
    input  fix_t in_1,
    output logic valid_out,
    output fix_t log_in_0,
    output fix_t in_0_bypass,
    output fix_t in_1_bypass
);

    logic v0;
    logic v1;
    logic v2;
    fix_t a0;
    fix_t b0;
    fix_t a1;
    fix_t b1;
    fix_t a2;
    fix_t b2;
    lzc_t lzc_next;
    lzc_t lzc1;
    fix_t log_next;
    fix_t log2_r;

    always_comb begin
        lzc_next = lead_zeros(a0);
        log_next = log_of(a1, lzc1);  // zero in_0 comes out as log 0
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            v0 <= 1'b0;
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else if (en) begin
            v0 <= valid_in;
            v1 <= v0;
            v2 <= v1;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            a0     <= in_0;  // stage 0 registers the raw pair
            b0     <= in_1;
            a1     <= a0;
            b1     <= b0;
            lzc1   <= lzc_next;
            a2     <= a1;
            b2     <= b1;
            log2_r <= log_next;
        end
    end

    assign valid_out   = v2;
    assign log_in_0    = log2_r;
    assign in_0_bypass = a2;
    assign in_1_bypass = b2;

endmodule

`default_nettype wire

// ==== verilog/log_arith_pkg.sv ====
`default_nettype none

package log_arith_pkg;

    localparam int data_w     = 16;
    localparam int frac_w     = 10;
    localparam int int_w      = data_w - frac_w;  // integer bits of a Q6.10 value
    localparam int len_w      = 8;
    localparam int pipe_depth = 6;
    localparam int lzc_w      = 4;

    typedef logic [data_w-1:0]       fix_t;
    typedef logic signed [data_w:0]  log_t;       // one extra integer bit so sums cannot wrap
    typedef logic [len_w-1:0]        job_len_t;
    typedef logic [lzc_w-1:0]        lzc_t;

    typedef enum logic {op_mul, op_div} arith_op_e;

    typedef enum logic [1:0] {st_idle, st_run, st_drain} job_state_e;

    typedef struct packed {
        logic valid;
        logic zero;
        logic div_zero;
        log_t log_res;
    } combine_s;

    // priority encoder where a zero input falls through to the highest count
    function automatic lzc_t lead_zeros(fix_t x);
        lzc_t lz;
        lz = lzc_t'(data_w - 1);
        for (int i = 0; i < data_w; i++) begin
            if (x[i]) begin
                lz = lzc_t'(data_w - 1 - i);
            end
        end
        return lz;
    endfunction

    // approximate log2 takes its integer part from the leading one and its fraction below it
    function automatic fix_t log_of(fix_t x, lzc_t lz);
        fix_t                      norm;
        logic signed [int_w-1:0]   int_part;
        norm     = x << lz;
        int_part = int_w'(int_w - 1 - int'(lz));
        if (x == '0) begin
            return '0;
        end
        return {int_part, norm[data_w-2 -: frac_w]};
    endfunction

endpackage

`default_nettype wire
